/* Makefile */
SOURCES := $(shell cat compile.f)

.PHONY: all run clean

all: obj_dir/Vtb_line_card_reader

obj_dir/Vtb_line_card_reader: compile.f $(SOURCES)
	verilator --binary --assert --top-module tb_line_card_reader -f compile.f

run: obj_dir/Vtb_line_card_reader
	./obj_dir/Vtb_line_card_reader > run.log 2>&1 || true
	cat run.log
	grep -q "^STATUS: PASS$$" run.log

clean:
	rm -rf obj_dir run.log

/* bench/line_card_tests.txt */
// Columns in hex: ingress port, frame length in bytes, MAC selector
// The selector is the last MAC byte and its low two bits pick the output port
0 40 a4
1 08 17
2 f8 3e
3 09 c1
0 10 52
1 2d 6b
2 08 90
3 f8 0f
0 f8 d6
0 f8 23
1 41 79
2 11 ea
3 3f 44
1 f8 b5
2 27 0c
3 08 5d
0 0f 96
1 80 e1
2 f8 3a
2 f0 47
3 1b c8
0 64 0d
1 09 f2
3 c9 65
0 08 ab
2 33 1e
1 78 58

/* bench/tb_line_card_reader.sv */
`timescale 1ns/1ps

module tb_line_card_reader;

	// Test table capacity, three entries per frame
	localparam int MAX_FRAMES = 64;

	// One expected output beat
	typedef struct packed {
		frame_pkg::word_t data;
		logic [reader_cfg_pkg::WORD_BYTES-1:0] strb;
		logic last;
		frame_pkg::port_t dest;
	} beat_t;

	logic clk;
	logic rst_n;
	logic wr_valid;
	frame_pkg::port_t wr_port;
	frame_pkg::word_t wr_data;
	logic commit_valid;
	frame_pkg::port_t commit_port;
	logic lookup_valid;
	frame_pkg::port_t lookup_port;
	frame_pkg::mac_t lookup_mac;
	logic result_valid;
	frame_pkg::port_t result_port;
	frame_pkg::port_t result_dest;
	logic out_valid;
	frame_pkg::word_t out_data;
	logic [reader_cfg_pkg::WORD_BYTES-1:0] out_strb;
	logic out_last;
	frame_pkg::port_t out_dest;

	// Test table, unused entries keep their address-tagged fill
	logic [15:0] test_mem [3*MAX_FRAMES];
	int num_frames;
	logic tests_loaded;
	logic [31:0] lfsr_state;

	// Expected traffic per ingress port
	beat_t exp_beats [reader_cfg_pkg::NUM_PORTS][$];
	frame_pkg::mac_t exp_macs [reader_cfg_pkg::NUM_PORTS][$];

	// Ring words put in and words known to be read out
	int written_words [reader_cfg_pkg::NUM_PORTS];
	int freed_words [reader_cfg_pkg::NUM_PORTS];

	// Scoreboard position in the output stream
	logic committed_any;
	logic in_frame;
	frame_pkg::port_t cur_port;
	int frame_beats;

	line_card_reader i_line_card_reader (
		.clk(clk),
		.rst_n(rst_n),
		.wr_valid(wr_valid),
		.wr_port(wr_port),
		.wr_data(wr_data),
		.commit_valid(commit_valid),
		.commit_port(commit_port),
		.lookup_valid(lookup_valid),
		.lookup_port(lookup_port),
		.lookup_mac(lookup_mac),
		.result_valid(result_valid),
		.result_port(result_port),
		.result_dest(result_dest),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_strb(out_strb),
		.out_last(out_last),
		.out_dest(out_dest)
	);

	//////////////////////
	// Error output

	task automatic stop_run(input string why);
		$display("error at time %0t: %s", $time, why);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] want);
		$display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, want);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	//////////////////////
	// Frame bytes

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	// One step per bit
	task automatic next_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			b[i] = lfsr_state[0];
		end
	endtask

	// Table entry left unset by the data file, never a valid port
	function automatic logic [15:0] unset_entry(input int i);
		return 16'hf000 | 16'(i);
	endfunction

	//////////////////////
	// Frame writer

	task automatic drive_word(input frame_pkg::port_t port, input frame_pkg::word_t data);
		wr_valid = 1'b1;
		wr_port = port;
		wr_data = data;
		@(posedge clk);
		#1;
		wr_valid = 1'b0;
	endtask

	task automatic write_frame(input frame_pkg::port_t port, input frame_pkg::len_t len,
			input logic [7:0] sel);
		frame_pkg::word_t word;
		frame_pkg::mac_t mac;
		logic [7:0] b;
		beat_t beat;
		int nwords;
		int remaining;
		nwords = (int'(len) + 7) / 8;
		remaining = int'(len);
		mac = '0;
		// Hold off until the ring has room for header and body
		while (written_words[port] - freed_words[port] + nwords + 1 > reader_cfg_pkg::RING_WORDS) begin
			@(posedge clk);
			#1;
		end
		drive_word(port, frame_pkg::word_t'(len));
		for (int w = 0; w < nwords; w++) begin
			for (int k = 0; k < reader_cfg_pkg::WORD_BYTES; k++) begin
				// Last MAC byte is the selector itself
				if (w == 0 && k == 5)
					b = sel;
				else
					next_byte(b);
				if (w == 0 && k < 6)
					mac = {mac[39:0], b};
				word[8*k +: 8] = b;
			end
			beat.data = word;
			// Tail strobe covers only the bytes left
			beat.strb = (remaining >= reader_cfg_pkg::WORD_BYTES) ? '1
				: 8'((16'd1 << remaining) - 16'd1);
			beat.last = (w == nwords - 1);
			beat.dest = sel[reader_cfg_pkg::PORT_BITS-1:0];
			exp_beats[port].push_back(beat);
			if (w == 0)
				exp_macs[port].push_back(mac);
			remaining -= reader_cfg_pkg::WORD_BYTES;
			drive_word(port, word);
		end
		written_words[port] += nwords + 1;
		commit_valid = 1'b1;
		commit_port = port;
		committed_any = 1'b1;
		@(posedge clk);
		#1;
		commit_valid = 1'b0;
	endtask

	//////////////////////
	// Scoreboard

	// Lookups per port come in commit order
	task automatic match_lookup();
		frame_pkg::mac_t want;
		assert (exp_macs[lookup_port].size() > 0)
			else stop_run($sformatf("lookup from port %0d with no frame waiting", lookup_port));
		want = exp_macs[lookup_port].pop_front();
		assert (lookup_mac == want)
			else report_mismatch("lookup_mac", 64'(lookup_mac), 64'(want));
	endtask

	task automatic score_beat();
		beat_t want;
		frame_pkg::word_t mask;
		int found;
		// A new frame is claimed by the port whose next word1 it carries
		if (!in_frame) begin
			found = -1;
			for (int p = reader_cfg_pkg::NUM_PORTS - 1; p >= 0; p--) begin
				if (exp_beats[p].size() > 0 && exp_beats[p][0].data == out_data)
					found = p;
			end
			assert (found >= 0) else stop_run("output beat starts no pending frame");
			cur_port = frame_pkg::port_t'(found);
			in_frame = 1'b1;
			frame_beats = 0;
		end
		assert (exp_beats[cur_port].size() > 0) else stop_run("output beat past end of frame");
		want = exp_beats[cur_port].pop_front();
		for (int k = 0; k < reader_cfg_pkg::WORD_BYTES; k++) begin
			mask[8*k +: 8] = {8{want.strb[k]}};
		end
		assert ((out_data & mask) == (want.data & mask))
			else report_mismatch("out_data", out_data, want.data);
		assert (out_strb == want.strb)
			else report_mismatch("out_strb", 64'(out_strb), 64'(want.strb));
		assert (out_last == want.last)
			else report_mismatch("out_last", 64'(out_last), 64'(want.last));
		assert (out_dest == want.dest)
			else report_mismatch("out_dest", 64'(out_dest), 64'(want.dest));
		frame_beats++;
		// Whole frame read out, header included
		if (out_last) begin
			in_frame = 1'b0;
			freed_words[cur_port] += frame_beats + 1;
		end
	endtask

	function automatic logic queues_empty();
		for (int p = 0; p < reader_cfg_pkg::NUM_PORTS; p++) begin
			if (exp_beats[p].size() != 0 || exp_macs[p].size() != 0)
				return 1'b0;
		end
		return 1'b1;
	endfunction

	//////////////////////
	// Processes

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Main sequence
	initial begin
		rst_n = 1'b0;
		wr_valid = 1'b0;
		wr_port = '0;
		wr_data = '0;
		commit_valid = 1'b0;
		commit_port = '0;
		committed_any = 1'b0;
		tests_loaded = 1'b0;
		lfsr_state = 32'hae80;
		for (int p = 0; p < reader_cfg_pkg::NUM_PORTS; p++) begin
			written_words[p] = 0;
		end
		for (int i = 0; i < 3 * MAX_FRAMES; i++) begin
			test_mem[i] = unset_entry(i);
		end
		$readmemh("bench/line_card_tests.txt", test_mem);
		num_frames = 0;
		while (num_frames < MAX_FRAMES && test_mem[3*num_frames] != unset_entry(3*num_frames))
			num_frames++;
		tests_loaded = 1'b1;
		assert (num_frames > 0) else stop_run("no frames read from bench/line_card_tests.txt");
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int i = 0; i < num_frames; i++) begin
			assert (test_mem[3*i] < 16'(reader_cfg_pkg::NUM_PORTS)
				&& test_mem[3*i+1] >= 16'd8 && test_mem[3*i+1] <= 16'd248)
				else stop_run($sformatf("test line %0d has a bad port or length", i + 1));
			write_frame(frame_pkg::port_t'(test_mem[3*i]), frame_pkg::len_t'(test_mem[3*i+1]),
				8'(test_mem[3*i+2]));
		end
		// Drain, then leave room for stray beats
		while (!queues_empty())
			@(negedge clk);
		repeat (20) @(negedge clk);
		if (queues_empty() && !in_frame) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("error at time %0t: frames left unfinished at the end", $time);
			$display("STATUS: FAIL");
			$fatal(1, "scoreboard not empty");
		end
	end

	// Lookup responder, fixed three-cycle answer
	initial begin
		int cycle;
		int due_q [$];
		frame_pkg::port_t port_q [$];
		frame_pkg::port_t dest_q [$];
		cycle = 0;
		result_valid = 1'b0;
		result_port = '0;
		result_dest = '0;
		forever begin
			@(posedge clk);
			#1;
			cycle++;
			result_valid = 1'b0;
			if (due_q.size() > 0 && due_q[0] == cycle) begin
				result_valid = 1'b1;
				result_port = port_q.pop_front();
				result_dest = dest_q.pop_front();
				due_q.delete(0);
			end
			@(negedge clk);
			// Destination from the low bits of the last MAC byte
			if (rst_n && lookup_valid) begin
				due_q.push_back(cycle + 3);
				port_q.push_back(lookup_port);
				dest_q.push_back(lookup_mac[reader_cfg_pkg::PORT_BITS-1:0]);
			end
		end
	end

	// Output monitor, mid-cycle sampling
	initial begin
		in_frame = 1'b0;
		cur_port = '0;
		frame_beats = 0;
		for (int p = 0; p < reader_cfg_pkg::NUM_PORTS; p++) begin
			freed_words[p] = 0;
		end
		forever begin
			@(negedge clk);
			if (rst_n) begin
				if (!committed_any) begin
					assert (!out_valid)
						else stop_run("out_valid high before the first commit");
					assert (!lookup_valid)
						else stop_run("lookup_valid high before the first commit");
				end
				if (lookup_valid)
					match_lookup();
				if (out_valid)
					score_beat();
			end
		end
	end

	// Watchdog
	initial begin
		wait (tests_loaded);
		repeat (200 * num_frames + 100) @(posedge clk);
		$display("error at time %0t: watchdog expired with frames still pending", $time);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog timeout");
	end

endmodule

/* compile.f */
src/reader_cfg_pkg.sv
src/frame_pkg.sv
src/read_tag_fifo.sv
src/frame_ram.sv
src/port_scheduler.sv
src/frame_forwarder.sv
src/line_card_reader.sv
bench/tb_line_card_reader.sv

/* src/frame_forwarder.sv */
`timescale 1ns/1ps

module frame_forwarder (
	input logic clk,
	input logic rst_n,
	input logic fwd_start,
	input frame_pkg::port_t fwd_port,
	input frame_pkg::len_t fwd_len,
	input frame_pkg::word_t fwd_word1,
	input frame_pkg::port_t fwd_dest,
	input logic rd_valid,
	input frame_pkg::word_t rd_data,
	input frame_pkg::read_tag_t rd_tag,
	output logic fwd_rd,
	output frame_pkg::port_t fwd_rd_port,
	output logic fwd_busy,
	output logic fwd_done,
	output frame_pkg::port_t fwd_done_port,
	output logic out_valid,
	output frame_pkg::word_t out_data,
	output logic [reader_cfg_pkg::WORD_BYTES-1:0] out_strb,
	output logic out_last,
	output frame_pkg::port_t out_dest
);

	// Forwarding state
	logic busy;
	frame_pkg::port_t port;

	// Bytes still to request and still to emit, word1 excluded
	frame_pkg::len_t to_read;
	frame_pkg::len_t to_send;

	// Body word back from memory
	logic body_valid;

	assign body_valid = rd_valid && (rd_tag.kind == frame_pkg::rd_body);

	// One body read per cycle until the count runs out
	assign fwd_rd = busy && (to_read != '0);
	assign fwd_rd_port = port;
	assign fwd_busy = busy;
	assign fwd_done_port = port;

	//////////////////////
	// Counters and beat flags

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			to_read <= '0;
			to_send <= '0;
			out_valid <= 1'b0;
			out_last <= 1'b0;
			fwd_done <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			out_last <= 1'b0;
			fwd_done <= 1'b0;
			// First beat is the saved word1
			if (fwd_start) begin
				out_valid <= 1'b1;
				to_read <= fwd_len - frame_pkg::len_t'(reader_cfg_pkg::WORD_BYTES);
				if (fwd_len > frame_pkg::len_t'(reader_cfg_pkg::WORD_BYTES)) begin
					busy <= 1'b1;
					to_send <= fwd_len - frame_pkg::len_t'(reader_cfg_pkg::WORD_BYTES);
				end else begin
					// Single-word frame ends here
					out_last <= 1'b1;
					fwd_done <= 1'b1;
					to_send <= '0;
				end
			end
			if (fwd_rd) begin
				if (to_read > frame_pkg::len_t'(reader_cfg_pkg::WORD_BYTES))
					to_read <= to_read - frame_pkg::len_t'(reader_cfg_pkg::WORD_BYTES);
				else
					to_read <= '0;
			end
			// Body beats as data returns
			if (body_valid) begin
				out_valid <= 1'b1;
				if (to_send > frame_pkg::len_t'(reader_cfg_pkg::WORD_BYTES)) begin
					to_send <= to_send - frame_pkg::len_t'(reader_cfg_pkg::WORD_BYTES);
				end else begin
					to_send <= '0;
					busy <= 1'b0;
					out_last <= 1'b1;
					fwd_done <= 1'b1;
				end
			end
		end
	end

	//////////////////////
	// Beat payload

	always_ff @(posedge clk) begin
		if (fwd_start) begin
			port <= fwd_port;
			out_data <= fwd_word1;
			out_dest <= fwd_dest;
			if (fwd_len > frame_pkg::len_t'(reader_cfg_pkg::WORD_BYTES))
				out_strb <= '1;
			else
				out_strb <= frame_pkg::strobe_of_count(fwd_len);
		end else if (body_valid) begin
			out_data <= rd_data;
			// Partial strobe only on the tail
			if (to_send > frame_pkg::len_t'(reader_cfg_pkg::WORD_BYTES))
				out_strb <= '1;
			else
				out_strb <= frame_pkg::strobe_of_count(to_send);
		end
	end

	// Body data only returns for a frame in progress
	a_body_while_busy: assert property (@(posedge clk) disable iff (!rst_n) body_valid |-> busy);

endmodule

/* src/frame_pkg.sv */
package frame_pkg;

	//////////////////////
	// Frame fields

	typedef logic [47:0] mac_t;
	typedef logic [reader_cfg_pkg::WORD_BITS-1:0] word_t;
	typedef logic [reader_cfg_pkg::LEN_BITS-1:0] len_t;
	typedef logic [reader_cfg_pkg::PORT_BITS-1:0] port_t;

	//////////////////////
	// Read bookkeeping

	// Why a memory read was issued
	typedef enum logic [1:0] {
		rd_header,
		rd_word1,
		rd_body
	} read_kind_t;

	// Travels alongside each read until its data returns
	typedef struct packed {
		read_kind_t kind;
		port_t port;
	} read_tag_t;

	// Scheduler view of one ingress port
	typedef enum logic [2:0] {
		ps_idle,
		ps_header,
		ps_word1,
		ps_lookup,
		ps_fwd_ready,
		ps_forwarding
	} port_state_t;

	// Destination MAC from the first frame word
	// Frame byte 0 sits in the low byte of the word and is the MAC's top byte
	function automatic mac_t mac_of_word(input word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24], w[39:32], w[47:40]};
	endfunction

	// Low-aligned byte strobe for a tail of 1 to 8 bytes
	function automatic logic [reader_cfg_pkg::WORD_BYTES-1:0] strobe_of_count(input len_t count);
		logic [reader_cfg_pkg::WORD_BYTES-1:0] strb;
		for (int i = 0; i < reader_cfg_pkg::WORD_BYTES; i++) begin
			strb[i] = (count > len_t'(i));
		end
		return strb;
	endfunction

endpackage

/* src/frame_ram.sv */
`timescale 1ns/1ps

module frame_ram (
	input logic clk,
	input logic rst_n,
	input logic wr_valid,
	input frame_pkg::port_t wr_port,
	input frame_pkg::word_t wr_data,
	input logic commit_valid,
	input frame_pkg::port_t commit_port,
	input logic sched_rd,
	input frame_pkg::port_t sched_rd_port,
	input frame_pkg::read_kind_t sched_rd_kind,
	input logic fwd_rd,
	input frame_pkg::port_t fwd_rd_port,
	output logic [reader_cfg_pkg::NUM_PORTS-1:0] port_has_data,
	output logic rd_valid,
	output frame_pkg::word_t rd_data,
	output frame_pkg::read_tag_t rd_tag
);

	// One ring per port, addressed as {port, ring index}
	frame_pkg::word_t mem [reader_cfg_pkg::NUM_PORTS*reader_cfg_pkg::RING_WORDS];

	// Per-port pointers with wrap bit
	logic [reader_cfg_pkg::PTR_BITS-1:0] wr_ptr [reader_cfg_pkg::NUM_PORTS];
	logic [reader_cfg_pkg::PTR_BITS-1:0] cmt_ptr [reader_cfg_pkg::NUM_PORTS];
	logic [reader_cfg_pkg::PTR_BITS-1:0] rd_ptr [reader_cfg_pkg::NUM_PORTS];

	// Merged read request
	logic rd_req;
	frame_pkg::port_t rd_port;
	frame_pkg::read_tag_t req_tag;

	// First pipeline stage of the read path
	logic s1_valid;
	logic [reader_cfg_pkg::PORT_BITS+reader_cfg_pkg::PTR_BITS-2:0] s1_addr;

	// Fill level of the ring being written
	logic [reader_cfg_pkg::PTR_BITS-1:0] wr_fill;

	//////////////////////
	// Request merge

	// Scheduler and forwarder never request in the same cycle
	assign rd_req = sched_rd || fwd_rd;
	assign rd_port = sched_rd ? sched_rd_port : fwd_rd_port;

	always_comb begin
		req_tag.kind = sched_rd ? sched_rd_kind : frame_pkg::rd_body;
		req_tag.port = rd_port;
	end

	// Unread committed words per port
	always_comb begin
		for (int p = 0; p < reader_cfg_pkg::NUM_PORTS; p++) begin
			port_has_data[p] = (cmt_ptr[p] != rd_ptr[p]);
		end
	end

	assign wr_fill = wr_ptr[wr_port] - rd_ptr[wr_port];

	//////////////////////
	// Pointers

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int p = 0; p < reader_cfg_pkg::NUM_PORTS; p++) begin
				wr_ptr[p] <= '0;
				cmt_ptr[p] <= '0;
				rd_ptr[p] <= '0;
			end
			s1_valid <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			if (wr_valid)
				wr_ptr[wr_port] <= wr_ptr[wr_port] + 1'b1;
			// A commit also covers a word written in the same cycle
			if (commit_valid) begin
				if (wr_valid && (wr_port == commit_port))
					cmt_ptr[commit_port] <= wr_ptr[commit_port] + 1'b1;
				else
					cmt_ptr[commit_port] <= wr_ptr[commit_port];
			end
			if (rd_req)
				rd_ptr[rd_port] <= rd_ptr[rd_port] + 1'b1;
			s1_valid <= rd_req;
			rd_valid <= s1_valid;
		end
	end

	//////////////////////
	// Memory

	// Write port
	always_ff @(posedge clk) begin
		if (wr_valid)
			mem[{wr_port, wr_ptr[wr_port][reader_cfg_pkg::PTR_BITS-2:0]}] <= wr_data;
	end

	// Address stage, then data stage
	always_ff @(posedge clk) begin
		s1_addr <= {rd_port, rd_ptr[rd_port][reader_cfg_pkg::PTR_BITS-2:0]};
		rd_data <= mem[s1_addr];
	end

	// Tag follows the read through the pipeline
	read_tag_fifo i_read_tag_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(rd_req),
		.push_tag(req_tag),
		.pop(rd_valid),
		.head_tag(rd_tag),
		.empty()
	);

	//////////////////////
	// Checks

	// Scheduler must yield while the forwarder reads
	a_one_reader: assert property (@(posedge clk) disable iff (!rst_n) !(sched_rd && fwd_rd));

	// Writer stays behind the readers of its ring
	a_no_overfill: assert property (@(posedge clk) disable iff (!rst_n)
		wr_valid |-> (wr_fill < reader_cfg_pkg::PTR_BITS'(reader_cfg_pkg::RING_WORDS)));

	// Only committed words get read
	a_read_committed: assert property (@(posedge clk) disable iff (!rst_n)
		rd_req |-> (rd_ptr[rd_port] != cmt_ptr[rd_port]));

endmodule

/* src/line_card_reader.sv */
`timescale 1ns/1ps

module line_card_reader (
	input logic clk,
	input logic rst_n,
	input logic wr_valid,
	input frame_pkg::port_t wr_port,
	input frame_pkg::word_t wr_data,
	input logic commit_valid,
	input frame_pkg::port_t commit_port,
	output logic lookup_valid,
	output frame_pkg::port_t lookup_port,
	output frame_pkg::mac_t lookup_mac,
	input logic result_valid,
	input frame_pkg::port_t result_port,
	input frame_pkg::port_t result_dest,
	output logic out_valid,
	output frame_pkg::word_t out_data,
	output logic [reader_cfg_pkg::WORD_BYTES-1:0] out_strb,
	output logic out_last,
	output frame_pkg::port_t out_dest
);

	//////////////////////
	// Read requests and returns

	logic sched_rd;
	frame_pkg::port_t sched_rd_port;
	frame_pkg::read_kind_t sched_rd_kind;
	logic fwd_rd;
	frame_pkg::port_t fwd_rd_port;
	logic [reader_cfg_pkg::NUM_PORTS-1:0] port_has_data;
	logic rd_valid;
	frame_pkg::word_t rd_data;
	frame_pkg::read_tag_t rd_tag;

	//////////////////////
	// Scheduler to forwarder handover

	logic fwd_start;
	frame_pkg::port_t fwd_port;
	frame_pkg::len_t fwd_len;
	frame_pkg::word_t fwd_word1;
	frame_pkg::port_t fwd_dest;
	logic fwd_busy;
	logic fwd_done;
	frame_pkg::port_t fwd_done_port;

	// Shared frame memory with tagged reads
	frame_ram i_frame_ram (
		.clk(clk),
		.rst_n(rst_n),
		.wr_valid(wr_valid),
		.wr_port(wr_port),
		.wr_data(wr_data),
		.commit_valid(commit_valid),
		.commit_port(commit_port),
		.sched_rd(sched_rd),
		.sched_rd_port(sched_rd_port),
		.sched_rd_kind(sched_rd_kind),
		.fwd_rd(fwd_rd),
		.fwd_rd_port(fwd_rd_port),
		.port_has_data(port_has_data),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.rd_tag(rd_tag)
	);

	// Header parse and lookup dispatch
	port_scheduler i_port_scheduler (
		.clk(clk),
		.rst_n(rst_n),
		.port_has_data(port_has_data),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.rd_tag(rd_tag),
		.result_valid(result_valid),
		.result_port(result_port),
		.result_dest(result_dest),
		.fwd_busy(fwd_busy),
		.fwd_done(fwd_done),
		.fwd_done_port(fwd_done_port),
		.sched_rd(sched_rd),
		.sched_rd_port(sched_rd_port),
		.sched_rd_kind(sched_rd_kind),
		.lookup_valid(lookup_valid),
		.lookup_port(lookup_port),
		.lookup_mac(lookup_mac),
		.fwd_start(fwd_start),
		.fwd_port(fwd_port),
		.fwd_len(fwd_len),
		.fwd_word1(fwd_word1),
		.fwd_dest(fwd_dest)
	);

	// Output beats
	frame_forwarder i_frame_forwarder (
		.clk(clk),
		.rst_n(rst_n),
		.fwd_start(fwd_start),
		.fwd_port(fwd_port),
		.fwd_len(fwd_len),
		.fwd_word1(fwd_word1),
		.fwd_dest(fwd_dest),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.rd_tag(rd_tag),
		.fwd_rd(fwd_rd),
		.fwd_rd_port(fwd_rd_port),
		.fwd_busy(fwd_busy),
		.fwd_done(fwd_done),
		.fwd_done_port(fwd_done_port),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_strb(out_strb),
		.out_last(out_last),
		.out_dest(out_dest)
	);

endmodule

/* src/port_scheduler.sv */
`timescale 1ns/1ps

module port_scheduler (
	input logic clk,
	input logic rst_n,
	input logic [reader_cfg_pkg::NUM_PORTS-1:0] port_has_data,
	input logic rd_valid,
	input frame_pkg::word_t rd_data,
	input frame_pkg::read_tag_t rd_tag,
	input logic result_valid,
	input frame_pkg::port_t result_port,
	input frame_pkg::port_t result_dest,
	input logic fwd_busy,
	input logic fwd_done,
	input frame_pkg::port_t fwd_done_port,
	output logic sched_rd,
	output frame_pkg::port_t sched_rd_port,
	output frame_pkg::read_kind_t sched_rd_kind,
	output logic lookup_valid,
	output frame_pkg::port_t lookup_port,
	output frame_pkg::mac_t lookup_mac,
	output logic fwd_start,
	output frame_pkg::port_t fwd_port,
	output frame_pkg::len_t fwd_len,
	output frame_pkg::word_t fwd_word1,
	output frame_pkg::port_t fwd_dest
);

	// Per-port state and frame tables
	frame_pkg::port_state_t state [reader_cfg_pkg::NUM_PORTS];
	frame_pkg::len_t len_tbl [reader_cfg_pkg::NUM_PORTS];
	frame_pkg::word_t word1_tbl [reader_cfg_pkg::NUM_PORTS];
	frame_pkg::port_t dest_tbl [reader_cfg_pkg::NUM_PORTS];

	// Round-robin pointer
	frame_pkg::port_t rr_ptr;
	logic rr_hold;

	//////////////////////
	// Visit decision

	always_comb begin
		sched_rd = 1'b0;
		sched_rd_kind = frame_pkg::rd_header;
		fwd_start = 1'b0;
		rr_hold = 1'b0;
		case (state[rr_ptr])
			// New frame, fetch header and stay for word1
			frame_pkg::ps_idle: begin
				if (port_has_data[rr_ptr] && !fwd_busy) begin
					sched_rd = 1'b1;
					rr_hold = 1'b1;
				end
			end
			// Second read of the pair
			frame_pkg::ps_header: begin
				if (!fwd_busy) begin
					sched_rd = 1'b1;
					sched_rd_kind = frame_pkg::rd_word1;
				end else begin
					rr_hold = 1'b1;
				end
			end
			// Lookup done, hand over when the forwarder is free
			frame_pkg::ps_fwd_ready: begin
				if (!fwd_busy)
					fwd_start = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// Start payload straight from the tables
	assign sched_rd_port = rr_ptr;
	assign fwd_port = rr_ptr;
	assign fwd_len = len_tbl[rr_ptr];
	assign fwd_word1 = word1_tbl[rr_ptr];
	assign fwd_dest = dest_tbl[rr_ptr];

	//////////////////////
	// Control state

	// Each event below touches a port in a distinct state, so no two collide
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rr_ptr <= '0;
			lookup_valid <= 1'b0;
			for (int p = 0; p < reader_cfg_pkg::NUM_PORTS; p++) begin
				state[p] <= frame_pkg::ps_idle;
			end
		end else begin
			lookup_valid <= 1'b0;
			if (!rr_hold) begin
				if (rr_ptr == frame_pkg::port_t'(reader_cfg_pkg::NUM_PORTS - 1))
					rr_ptr <= '0;
				else
					rr_ptr <= rr_ptr + 1'b1;
			end
			if (sched_rd) begin
				if (sched_rd_kind == frame_pkg::rd_header)
					state[rr_ptr] <= frame_pkg::ps_header;
				else
					state[rr_ptr] <= frame_pkg::ps_word1;
			end
			if (fwd_start)
				state[rr_ptr] <= frame_pkg::ps_forwarding;
			// Word1 back, request the lookup
			if (rd_valid && (rd_tag.kind == frame_pkg::rd_word1)) begin
				state[rd_tag.port] <= frame_pkg::ps_lookup;
				lookup_valid <= 1'b1;
			end
			if (result_valid)
				state[result_port] <= frame_pkg::ps_fwd_ready;
			if (fwd_done)
				state[fwd_done_port] <= frame_pkg::ps_idle;
		end
	end

	//////////////////////
	// Tables and lookup payload

	always_ff @(posedge clk) begin
		if (rd_valid && (rd_tag.kind == frame_pkg::rd_header))
			len_tbl[rd_tag.port] <= rd_data[reader_cfg_pkg::LEN_BITS-1:0];
		if (rd_valid && (rd_tag.kind == frame_pkg::rd_word1)) begin
			word1_tbl[rd_tag.port] <= rd_data;
			lookup_port <= rd_tag.port;
			lookup_mac <= frame_pkg::mac_of_word(rd_data);
		end
		if (result_valid)
			dest_tbl[result_port] <= result_dest;
	end

	// Responder answers only outstanding requests
	a_result_expected: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> (state[result_port] == frame_pkg::ps_lookup));

endmodule

/* src/read_tag_fifo.sv */
`timescale 1ns/1ps

module read_tag_fifo (
	input logic clk,
	input logic rst_n,
	input logic push,
	input frame_pkg::read_tag_t push_tag,
	input logic pop,
	output frame_pkg::read_tag_t head_tag,
	output logic empty
);

	// Entry storage
	frame_pkg::read_tag_t tags [reader_cfg_pkg::TAG_DEPTH];

	// Pointers carry an extra wrap bit
	logic [$clog2(reader_cfg_pkg::TAG_DEPTH):0] wr_ptr;
	logic [$clog2(reader_cfg_pkg::TAG_DEPTH):0] rd_ptr;
	logic full;

	//////////////////////
	// Status

	// Same index, opposite wrap bits means full
	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[$clog2(reader_cfg_pkg::TAG_DEPTH)]
		!= rd_ptr[$clog2(reader_cfg_pkg::TAG_DEPTH)])
		&& (wr_ptr[$clog2(reader_cfg_pkg::TAG_DEPTH)-1:0]
		== rd_ptr[$clog2(reader_cfg_pkg::TAG_DEPTH)-1:0]);

	// Head is visible without a register stage
	assign head_tag = tags[rd_ptr[$clog2(reader_cfg_pkg::TAG_DEPTH)-1:0]];

	//////////////////////
	// Pointer update

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Tag write
	always_ff @(posedge clk) begin
		if (push)
			tags[wr_ptr[$clog2(reader_cfg_pkg::TAG_DEPTH)-1:0]] <= push_tag;
	end

	//////////////////////
	// Checks

	// More reads in flight than entries would lose a tag
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);

	// Data returned with no tag waiting
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

/* src/reader_cfg_pkg.sv */
package reader_cfg_pkg;

	//////////////////////
	// Port geometry

	// Ingress ports sharing the frame memory
	localparam int NUM_PORTS = 4;

	// Width of a port index
	localparam int PORT_BITS = 2;

	//////////////////////
	// Word geometry

	// Memory and output word width
	localparam int WORD_BITS = 64;

	// Bytes carried by one word
	localparam int WORD_BYTES = 8;

	//////////////////////
	// Ring and frame geometry

	// Words per port ring
	localparam int RING_WORDS = 64;

	// Ring pointer, one bit wider than the ring index for the wrap flag
	localparam int PTR_BITS = 7;

	// Frame length field in the header word
	localparam int LEN_BITS = 11;

	// Cycles from read request to read data
	localparam int RD_LATENCY = 2;

	// Read tags in flight, covers RD_LATENCY with margin
	localparam int TAG_DEPTH = 4;

endpackage
